/* all.f */
+incdir+include
hdl/ntt_pkg.sv
hdl/ntt_twiddle_rom.sv
hdl/ntt_coef_ram.sv
hdl/ntt_butterfly.sv
hdl/ntt_ctrl.sv
hdl/ntt_subsystem.sv
sim/ntt_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the NTT testbench with Verilator, runs it and scans the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module ntt_tb -f all.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vntt_tb 2>&1 | tee sim.log \
    || { echo "Simulation exited with an error"; exit 1; }

grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
    || { echo "No pass message in sim.log"; exit 1; }

/* include/ntt_tb_tasks.svh */
/*
  Tasks included inside ntt_tb. They use the testbench signals, Q, N and the
  counters declared before the include. Every wait loop is bounded.
*/
`ifndef NTT_TB_TASKS_SVH
`define NTT_TB_TASKS_SVH

// ============================================================
// Reference arithmetic mod Q
// ============================================================
function automatic coef_t add_q(coef_t a, coef_t b);
    return coef_t'((int'(a) + int'(b)) % Q);
endfunction

function automatic coef_t sub_q(coef_t a, coef_t b);
    return coef_t'((int'(a) + Q - int'(b)) % Q);
endfunction

function automatic coef_t mul_q(coef_t a, coef_t b);
    return coef_t'((int'(a) * int'(b)) % Q);
endfunction

function automatic coef_t rand_coef();
    return coef_t'($urandom % Q);
endfunction

// ============================================================
// Compare tasks
// ============================================================
task automatic check_coef(string name, coef_t got, coef_t exp);
    check_count++;
    if (got !== exp) begin
        $display("** Error @ %0t: %s got %0d expected %0d", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
        $display("** Error @ %0t: %s got %b expected %b", $time, name, got, exp);
        err_count++;
    end
endtask

// ============================================================
// Host port drivers
// ============================================================
task automatic load_poly(mem_sel_t sel, slot_t slot, coef_t vals [N]);
    for (int i = 0; i < N; i++) begin
        @(posedge clk);
        #1;
        load_en   = 1'b1;
        load_sel  = sel;
        load_addr = {slot, coef_addr_t'(i)};
        load_data = vals[i];
    end
    @(posedge clk);
    #1 load_en = 1'b0;
endtask

// rd_data is registered, so it is sampled one cycle after rd_en
task automatic read_coef(mem_addr_t addr, output coef_t val);
    @(posedge clk);
    #1;
    rd_en   = 1'b1;
    rd_addr = addr;
    @(posedge clk);
    #1;
    rd_en = 1'b0;
    val   = rd_data;
endtask

task automatic verify_slot(slot_t slot, coef_t exp [N]);
    coef_t val;
    for (int i = 0; i < N; i++) begin
        read_coef({slot, coef_addr_t'(i)}, val);
        check_coef($sformatf("rd_data[slot %0d][%0d]", slot, i), val, exp[i]);
    end
endtask

task automatic start_op(mode_t op, slot_t src, slot_t dst, logic acc);
    @(posedge clk);
    #1;
    mode       = op;
    ntt_slot   = src;
    pwo_slot   = dst;
    accumulate = acc;
    ntt_enable = 1'b1;
    @(posedge clk);
    #1 ntt_enable = 1'b0;
    check_flag("ntt_busy", ntt_busy, 1'b1);
endtask

// Busy must hold until a single done pulse, and fall with it
task automatic wait_done();
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < DONE_TIMEOUT) begin
        if (ntt_done === 1'b1) begin
            seen = 1'b1;
            check_flag("ntt_busy", ntt_busy, 1'b0);
        end else begin
            check_flag("ntt_busy", ntt_busy, 1'b1);
            @(posedge clk);
            #1 cycles++;
        end
    end
    if (!seen) begin
        $display("Timeout at %0t: ntt_done did not pulse within %0d cycles",
                 $time, DONE_TIMEOUT);
        err_count++;
    end else begin
        @(posedge clk);
        #1 check_flag("ntt_done", ntt_done, 1'b0);
    end
endtask

task automatic end_test(string name, int err_before);
    test_count++;
    if (err_count == err_before) begin
        $display("%-28s ok", name);
    end else begin
        test_fail++;
        $display("%-28s %0d errors", name, err_count - err_before);
    end
endtask

`endif

/* sim/ntt_tb.sv */
/*
  Directed testbench for the NTT engine at default parameters (N = 16, Q = 3329).
  Host loads and reads are issued only while ntt_busy is low.
*/
module ntt_tb
    import ntt_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          Q             = 3329;
    localparam int          N             = 16;
    localparam int unsigned SEED          = 32'hf694_c296;
    localparam int          DONE_TIMEOUT  = 2000;
    localparam int          ABORT_CYCLES  = 40;

    logic      clk;
    logic      rst_n;
    logic      zeroize;
    mode_t     mode;
    logic      ntt_enable;
    slot_t     ntt_slot;
    slot_t     pwo_slot;
    logic      accumulate;
    logic      load_en;
    mem_sel_t  load_sel;
    mem_addr_t load_addr;
    coef_t     load_data;
    logic      rd_en;
    mem_addr_t rd_addr;
    coef_t     rd_data;
    logic      ntt_busy;
    logic      ntt_done;

    int err_count;
    int check_count;
    int test_count;
    int test_fail;

    // Stimulus and expected polynomials shared by the tests
    coef_t poly_a [N];
    coef_t poly_b [N];
    coef_t poly_c [N];
    coef_t expect_poly [N];
    coef_t zero_poly [N];

    ntt_subsystem dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .zeroize    (zeroize),
        .mode       (mode),
        .ntt_enable (ntt_enable),
        .ntt_slot   (ntt_slot),
        .pwo_slot   (pwo_slot),
        .accumulate (accumulate),
        .load_en    (load_en),
        .load_sel   (load_sel),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .ntt_busy   (ntt_busy),
        .ntt_done   (ntt_done)
    );

    `include "ntt_tb_tasks.svh"

    always #5 clk = ~clk;

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic reset_protocol();
        int err_before;
        err_before = err_count;
        check_flag("ntt_busy", ntt_busy, 1'b0);
        check_flag("ntt_done", ntt_done, 1'b0);
        load_poly(sel_c, 2'd0, zero_poly);
        start_op(ct, 2'd0, 2'd0, 1'b0);
        wait_done();
        check_flag("ntt_busy", ntt_busy, 1'b0);
        verify_slot(2'd0, zero_poly);
        end_test("reset and start protocol", err_before);
    endtask

    // A delta transforms to all ones
    task automatic delta_forward();
        int err_before;
        err_before = err_count;
        foreach (poly_c[i]) begin
            poly_c[i]      = (i == 0) ? coef_t'(1) : '0;
            expect_poly[i] = coef_t'(1);
        end
        load_poly(sel_c, 2'd1, poly_c);
        start_op(ct, 2'd1, 2'd1, 1'b0);
        wait_done();
        verify_slot(2'd1, expect_poly);
        end_test("forward ntt of delta", err_before);
    endtask

    // Inverse has no 1/N scaling
    task automatic round_trip();
        int err_before;
        err_before = err_count;
        foreach (poly_a[i]) begin
            poly_a[i]      = rand_coef();
            expect_poly[i] = mul_q(coef_t'(N), poly_a[i]);
        end
        load_poly(sel_c, 2'd2, poly_a);
        start_op(ct, 2'd2, 2'd2, 1'b0);
        wait_done();
        start_op(gs, 2'd2, 2'd2, 1'b0);
        wait_done();
        verify_slot(2'd2, expect_poly);
        end_test("ct then gs round trip", err_before);
    endtask

    // Source slot 1 holds all ones, so a stray accumulate shows up
    task automatic pointwise_ops();
        int err_before;
        err_before = err_count;
        foreach (poly_a[i]) begin
            poly_a[i] = rand_coef();
            poly_b[i] = rand_coef();
        end
        load_poly(sel_a, 2'd0, poly_a);
        load_poly(sel_b, 2'd0, poly_b);

        foreach (expect_poly[i]) begin
            expect_poly[i] = add_q(poly_a[i], poly_b[i]);
        end
        start_op(pwa, 2'd1, 2'd3, 1'b0);
        wait_done();
        verify_slot(2'd3, expect_poly);

        foreach (expect_poly[i]) begin
            expect_poly[i] = sub_q(poly_a[i], poly_b[i]);
        end
        start_op(pws, 2'd1, 2'd3, 1'b0);
        wait_done();
        verify_slot(2'd3, expect_poly);

        foreach (expect_poly[i]) begin
            expect_poly[i] = mul_q(poly_a[i], poly_b[i]);
        end
        start_op(pwm, 2'd1, 2'd3, 1'b0);
        wait_done();
        verify_slot(2'd3, expect_poly);
        end_test("pointwise pwa pws pwm", err_before);
    endtask

    // A and B still hold the pointwise operands
    task automatic pwm_accumulate();
        int err_before;
        err_before = err_count;
        foreach (poly_c[i]) begin
            poly_c[i]      = rand_coef();
            expect_poly[i] = add_q(poly_c[i], mul_q(poly_a[i], poly_b[i]));
        end
        load_poly(sel_c, 2'd0, poly_c);
        start_op(pwm, 2'd0, 2'd3, 1'b1);
        wait_done();
        verify_slot(2'd3, expect_poly);
        end_test("pwm with accumulate", err_before);
    endtask

    task automatic zeroize_abort();
        int err_before;
        err_before = err_count;
        start_op(ct, 2'd2, 2'd2, 1'b0);
        repeat (ABORT_CYCLES) begin
            @(posedge clk);
            #1 check_flag("ntt_busy", ntt_busy, 1'b1);
        end
        zeroize = 1'b1;
        @(posedge clk);
        #1 zeroize = 1'b0;
        check_flag("ntt_busy", ntt_busy, 1'b0);
        check_flag("ntt_done", ntt_done, 1'b0);
        // No late done pulse after the abort
        repeat (4) begin
            @(posedge clk);
            #1 check_flag("ntt_done", ntt_done, 1'b0);
        end
        for (int s = 0; s < 4; s++) begin
            verify_slot(slot_t'(s), zero_poly);
        end
        end_test("zeroize abort", err_before);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        zeroize     = 1'b0;
        mode        = ct;
        ntt_enable  = 1'b0;
        ntt_slot    = '0;
        pwo_slot    = '0;
        accumulate  = 1'b0;
        load_en     = 1'b0;
        load_sel    = sel_c;
        load_addr   = '0;
        load_data   = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_fail   = 0;
        foreach (zero_poly[i]) zero_poly[i] = '0;
        void'($urandom(SEED));

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        reset_protocol();
        delta_forward();
        round_trip();
        pointwise_ops();
        pwm_accumulate();
        zeroize_abort();

        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 test_count, test_fail, check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* hdl/ntt_subsystem.sv */
/*
  NTT engine top. Host load and readback are only valid while ntt_busy is low.
  Memory C holds four slots, A and B one polynomial each.
*/
module ntt_subsystem
    import ntt_pkg::*;
#(
    parameter int Q    = 3329,
    parameter int N    = 16,
    parameter int ROOT = 1062
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      zeroize,
    input  mode_t     mode,
    input  logic      ntt_enable,
    input  slot_t     ntt_slot,
    input  slot_t     pwo_slot,
    input  logic      accumulate,
    input  logic      load_en,
    input  mem_sel_t  load_sel,
    input  mem_addr_t load_addr,
    input  coef_t     load_data,
    input  logic      rd_en,
    input  mem_addr_t rd_addr,
    output coef_t     rd_data,
    output logic      ntt_busy,
    output logic      ntt_done
);

    mem_req_t   ctrl_rd_req;
    mem_req_t   ctrl_wr_req;
    mem_req_t   ab_rd_req;
    mem_req_t   c_rd_req;
    mem_req_t   c_wr_req;
    mem_req_t   a_wr_req;
    mem_req_t   b_wr_req;
    coef_addr_t tw_idx;
    coef_t      twiddle;
    mode_t      op_mode;
    logic       use_acc;
    logic       load_u;
    logic       load_v;
    logic       pw_mode;
    logic       x_phase;
    coef_t      c_rd_data;
    coef_t      a_rd_data;
    coef_t      b_rd_data;
    coef_t      c_wr_data;
    coef_t      u_reg;
    coef_t      v_reg;
    coef_t      v_op;
    bf_op_t     bf_op;
    bf_res_t    bf_res;

    ntt_ctrl #(
        .N(N)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .zeroize    (zeroize),
        .ntt_enable (ntt_enable),
        .mode       (mode),
        .ntt_slot   (ntt_slot),
        .pwo_slot   (pwo_slot),
        .accumulate (accumulate),
        .rd_req     (ctrl_rd_req),
        .wr_req     (ctrl_wr_req),
        .ab_rd_req  (ab_rd_req),
        .tw_idx     (tw_idx),
        .op_mode    (op_mode),
        .use_acc    (use_acc),
        .load_u     (load_u),
        .load_v     (load_v),
        .busy       (ntt_busy),
        .done       (ntt_done)
    );

    ntt_twiddle_rom #(
        .Q    (Q),
        .N    (N),
        .ROOT (ROOT)
    ) u_rom (
        .tw_idx  (tw_idx),
        .twiddle (twiddle)
    );

    // ============================================================
    // Operand capture
    // ============================================================
    always_ff @(posedge clk) begin
        if (load_u) begin
            u_reg <= c_rd_data;
        end
        if (load_v) begin
            v_reg <= c_rd_data;
        end
    end

    // x is written the cycle after v arrives, y the cycle after that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_phase <= 1'b0;
        end else begin
            x_phase <= load_v;
        end
    end

    // v feeds straight from memory while it is being captured
    assign v_op    = load_v ? c_rd_data : v_reg;
    assign pw_mode = (op_mode inside {pwm, pwa, pws});

    always_comb begin
        if (pw_mode) begin
            bf_op = '{u: a_rd_data, v: b_rd_data, w: (use_acc ? c_rd_data : '0),
                      mode: op_mode};
        end else begin
            bf_op = '{u: u_reg, v: v_op, w: twiddle, mode: op_mode};
        end
    end

    ntt_butterfly #(
        .Q(Q)
    ) u_bf (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (bf_op),
        .res   (bf_res)
    );

    // ============================================================
    // Memory port muxing, host owns the ports while idle
    // ============================================================
    assign c_rd_req  = ntt_busy ? ctrl_rd_req : {rd_en, rd_addr};
    assign c_wr_req  = ntt_busy ? ctrl_wr_req : {load_en && (load_sel == sel_c), load_addr};
    assign c_wr_data = !ntt_busy ? load_data
                     : (pw_mode || x_phase) ? bf_res.x : bf_res.y;
    assign a_wr_req  = {load_en && (load_sel == sel_a) && !ntt_busy, load_addr};
    assign b_wr_req  = {load_en && (load_sel == sel_b) && !ntt_busy, load_addr};
    assign rd_data   = c_rd_data;

    ntt_coef_ram #(
        .DEPTH(4 * N)
    ) c_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .wr_req  (c_wr_req),
        .wr_data (c_wr_data),
        .rd_req  (c_rd_req),
        .rd_data (c_rd_data)
    );

    ntt_coef_ram #(
        .DEPTH(N)
    ) a_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .wr_req  (a_wr_req),
        .wr_data (load_data),
        .rd_req  (ab_rd_req),
        .rd_data (a_rd_data)
    );

    ntt_coef_ram #(
        .DEPTH(N)
    ) b_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .wr_req  (b_wr_req),
        .wr_data (load_data),
        .rd_req  (ab_rd_req),
        .rd_data (b_rd_data)
    );

endmodule

/* hdl/ntt_ctrl.sv */
/*
  Sequencer for ct/gs butterflies and the pointwise stream.
  One butterfly every five cycles, pointwise results land two cycles after the read.
*/
module ntt_ctrl
    import ntt_pkg::*;
#(
    parameter int N = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       zeroize,
    input  logic       ntt_enable,
    input  mode_t      mode,
    input  slot_t      ntt_slot,
    input  slot_t      pwo_slot,
    input  logic       accumulate,
    output mem_req_t   rd_req,
    output mem_req_t   wr_req,
    output mem_req_t   ab_rd_req,
    output coef_addr_t tw_idx,
    output mode_t      op_mode,
    output logic       use_acc,
    output logic       load_u,
    output logic       load_v,
    output logic       busy,
    output logic       done
);

    typedef enum logic [3:0] {
        idle,
        rd_u,
        rd_v,
        calc,
        wr_x,
        wr_y,
        pw_run,
        pw_drain,
        finish
    } state_t;

    state_t     state;
    mode_t      mode_q;
    slot_t      src_slot;
    slot_t      dst_slot;
    logic       acc_q;
    logic [4:0] len;
    coef_addr_t grp;
    coef_addr_t bf;
    coef_addr_t tw_k;
    coef_addr_t pw_idx;
    mem_req_t   wr_pipe [2];
    coef_addr_t u_idx;
    coef_addr_t v_idx;
    logic       is_ct;
    logic       last_bf;
    logic       last_grp;
    logic       last_stage;

    // ============================================================
    // Butterfly addressing
    // ============================================================
    assign is_ct = (mode_q == ct);
    assign u_idx = coef_addr_t'(grp + bf);
    assign v_idx = coef_addr_t'(grp + bf + len);

    assign last_bf    = ({1'b0, bf} == len - 5'd1);
    assign last_grp   = (int'(grp) + 2 * int'(len) >= N);
    assign last_stage = is_ct ? (len == 5'd1) : (int'(len) == N / 2);

    // ============================================================
    // State machine
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            mode_q     <= ct;
            src_slot   <= '0;
            dst_slot   <= '0;
            acc_q      <= 1'b0;
            len        <= '0;
            grp        <= '0;
            bf         <= '0;
            tw_k       <= '0;
            pw_idx     <= '0;
            wr_pipe[0] <= '0;
            wr_pipe[1] <= '0;
        end else if (zeroize) begin
            state      <= idle;
            wr_pipe[0] <= '0;
            wr_pipe[1] <= '0;
        end else begin
            // Write address follows the read by two cycles
            wr_pipe[0] <= {(state == pw_run), dst_slot, pw_idx};
            wr_pipe[1] <= wr_pipe[0];

            case (state)
                idle: begin
                    if (ntt_enable) begin
                        mode_q   <= mode;
                        src_slot <= ntt_slot;
                        dst_slot <= pwo_slot;
                        acc_q    <= accumulate;
                        grp      <= '0;
                        bf       <= '0;
                        pw_idx   <= '0;
                        if (mode == ct) begin
                            len   <= 5'(N / 2);
                            tw_k  <= coef_addr_t'(1);
                            state <= rd_u;
                        end else if (mode == gs) begin
                            len   <= 5'd1;
                            tw_k  <= coef_addr_t'(N - 1);
                            state <= rd_u;
                        end else begin
                            state <= pw_run;
                        end
                    end
                end
                rd_u: state <= rd_v;
                rd_v: state <= calc;
                calc: state <= wr_x;
                wr_x: state <= wr_y;
                wr_y: begin
                    state <= rd_u;
                    if (!last_bf) begin
                        bf <= bf + 4'd1;
                    end else begin
                        bf   <= '0;
                        // One twiddle per group
                        tw_k <= is_ct ? tw_k + 4'd1 : tw_k - 4'd1;
                        if (!last_grp) begin
                            grp <= coef_addr_t'(grp + (len << 1));
                        end else begin
                            grp <= '0;
                            if (last_stage) begin
                                state <= finish;
                            end else begin
                                len <= is_ct ? (len >> 1) : (len << 1);
                            end
                        end
                    end
                end
                pw_run: begin
                    pw_idx <= pw_idx + 4'd1;
                    if (int'(pw_idx) == N - 1) begin
                        state <= pw_drain;
                    end
                end
                // Last write leaves wr_pipe[1] in the cycle it goes empty
                pw_drain: begin
                    if (!wr_pipe[0].en) begin
                        state <= finish;
                    end
                end
                finish:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // ============================================================
    // Outputs
    // ============================================================
    assign load_u  = (state == rd_v);
    assign load_v  = (state == calc);
    assign busy    = !(state inside {idle, finish});
    assign done    = (state == finish);
    assign tw_idx  = tw_k;
    assign op_mode = mode_q;
    assign use_acc = acc_q && (mode_q == pwm);

    always_comb begin
        rd_req    = '0;
        wr_req    = wr_pipe[1];
        ab_rd_req = '0;
        case (state)
            rd_u: rd_req = {1'b1, src_slot, u_idx};
            rd_v: rd_req = {1'b1, src_slot, v_idx};
            wr_x: wr_req = {1'b1, src_slot, u_idx};
            wr_y: wr_req = {1'b1, src_slot, v_idx};
            pw_run: begin
                rd_req    = {1'b1, src_slot, pw_idx};
                ab_rd_req = {1'b1, 2'b00, pw_idx};
            end
            default: ;
        endcase
    end

endmodule

/* hdl/ntt_butterfly.sv */
/*
  Modular butterfly with one register stage. Inputs must already lie in 0..Q-1.
  Reduction uses a plain remainder, fine for simulation but slow in silicon.
*/
module ntt_butterfly
    import ntt_pkg::*;
#(
    parameter int Q = 3329
) (
    input  logic    clk,
    input  logic    rst_n,
    input  bf_op_t  op,
    output bf_res_t res
);

    function automatic coef_t add_mod(coef_t a, coef_t b);
        logic [12:0] sum;
        sum = a + b;
        return (sum >= 13'(Q)) ? coef_t'(sum - 13'(Q)) : coef_t'(sum);
    endfunction

    function automatic coef_t sub_mod(coef_t a, coef_t b);
        logic [12:0] diff;
        diff = 13'(a) + 13'(Q) - 13'(b);
        return (a >= b) ? coef_t'(a - b) : coef_t'(diff);
    endfunction

    function automatic coef_t mul_mod(coef_t a, coef_t b);
        logic [23:0] prod;
        prod = a * b;
        return coef_t'(prod % 24'(Q));
    endfunction

    coef_t   t;
    coef_t   neg_w;
    bf_res_t res_n;

    // ============================================================
    // Arithmetic per mode
    // ============================================================
    always_comb begin
        t     = mul_mod(op.w, op.v);
        // GS runs on the inverse twiddle, -w mod Q
        neg_w = sub_mod('0, op.w);
        res_n = '0;
        case (op.mode)
            ct: begin
                res_n.x = add_mod(op.u, t);
                res_n.y = sub_mod(op.u, t);
            end
            gs: begin
                res_n.x = add_mod(op.u, op.v);
                res_n.y = mul_mod(sub_mod(op.u, op.v), neg_w);
            end
            pwm: res_n.x = add_mod(mul_mod(op.u, op.v), op.w);
            pwa: res_n.x = add_mod(op.u, op.v);
            pws: res_n.x = sub_mod(op.u, op.v);
            default: res_n = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res <= res_n;
        end
    end

endmodule

/* hdl/ntt_coef_ram.sv */
/*
  One write port, one registered read port. Read and write to one address
  in the same cycle returns the old word. Zeroize wipes everything in one cycle.
*/
module ntt_coef_ram
    import ntt_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     zeroize,
    input  mem_req_t wr_req,
    input  coef_t    wr_data,
    input  mem_req_t rd_req,
    output coef_t    rd_data
);

    localparam int AW = $clog2(DEPTH);

    coef_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_req.en) begin
            mem[wr_req.addr[AW-1:0]] <= wr_data;
        end
    end

    // Output holds its last word between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (zeroize) begin
            rd_data <= '0;
        end else if (rd_req.en) begin
            rd_data <= mem[rd_req.addr[AW-1:0]];
        end
    end

endmodule

/* hdl/ntt_twiddle_rom.sv */
/*
  Twiddle table, entry k = ROOT^bitrev(k) mod Q. ROOT must be a primitive 2N-th root.
*/
module ntt_twiddle_rom
    import ntt_pkg::*;
#(
    parameter int Q    = 3329,
    parameter int N    = 16,
    parameter int ROOT = 1062
) (
    input  coef_addr_t tw_idx,
    output coef_t      twiddle
);

    localparam int LOG_N = $clog2(N);

    function automatic int unsigned bit_rev(int unsigned k);
        int unsigned r;
        r = 0;
        for (int b = 0; b < LOG_N; b++) begin
            r = (r << 1) | ((k >> b) & 1);
        end
        return r;
    endfunction

    coef_t tw_table [N];

    // Entry 0 holds ROOT^0 and is never addressed
    for (genvar k = 0; k < N; k++) begin : g_entry
        localparam coef_t VAL = coef_t'(mod_pow(ROOT, bit_rev(k), Q));
        assign tw_table[k] = VAL;
    end

    assign twiddle = tw_table[tw_idx[LOG_N-1:0]];

endmodule

/* hdl/ntt_pkg.sv */
/*
  Shared types for the NTT engine. Widths assume N <= 16 and Q < 4096.
  C addresses are {slot, index}, so a slot spans 16 words.
*/
package ntt_pkg;

    // ============================================================
    // Widths with a meaning
    // ============================================================
    typedef logic [11:0] coef_t;
    typedef logic [3:0]  coef_addr_t;
    typedef logic [1:0]  slot_t;
    typedef logic [5:0]  mem_addr_t;

    // Operation selected on the mode input
    typedef enum logic [2:0] {
        ct,
        gs,
        pwm,
        pwa,
        pws
    } mode_t;

    // Target of a host load
    typedef enum logic [1:0] {
        sel_c,
        sel_a,
        sel_b
    } mem_sel_t;

    // ============================================================
    // Bundles
    // ============================================================
    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_req_t;

    // w carries the twiddle for ct/gs and the accumulate term for pwm
    typedef struct packed {
        coef_t u;
        coef_t v;
        coef_t w;
        mode_t mode;
    } bf_op_t;

    typedef struct packed {
        coef_t x;
        coef_t y;
    } bf_res_t;

    // Square and multiply, base^exp mod modulus
    function automatic int unsigned mod_pow(int unsigned base, int unsigned exp,
                                            int unsigned modulus);
        longint unsigned acc;
        longint unsigned sq;
        int unsigned     e;
        acc = 1;
        sq  = base % modulus;
        e   = exp;
        while (e != 0) begin
            if (e[0]) begin
                acc = (acc * sq) % modulus;
            end
            sq = (sq * sq) % modulus;
            e  = e >> 1;
        end
        return 32'(acc % modulus);
    endfunction

endpackage
